//--- hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int REG_W = 32;
    localparam int RA_W  = 5;

    localparam logic [RA_W-1:0] LINK_REG  = 5'd31;
    localparam logic [RA_W-1:0] RT_BGEZAL = 5'b10001;

    // major opcodes, instruction bits 31:26.
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // function field of SPECIAL, bits 5:0.
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_ADDU, ALU_SUB,
        ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_LUI, ALU_LINK
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP, SEL_ARITH, SEL_LOGIC, SEL_SHIFT, SEL_COMPARE, SEL_JUMP
    } alu_sel_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_OV   = 2'd1,
        EXC_RI   = 2'd2
    } exc_e;

endpackage

//--- hw/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    // decoded instruction as held between decode and execute.
    typedef struct packed {
        cpu_isa_pkg::alu_op_e               alu_op;
        cpu_isa_pkg::alu_sel_e              alu_sel;
        logic [cpu_isa_pkg::REG_W-1:0]      op_a;
        logic [cpu_isa_pkg::REG_W-1:0]      op_b;
        logic [cpu_isa_pkg::RA_W-1:0]       wd;
        logic                               wreg;
        logic [cpu_isa_pkg::REG_W-1:0]      pc;
        logic [cpu_isa_pkg::REG_W-1:0]      link_addr;
        logic                               in_delayslot;
        cpu_isa_pkg::exc_e                  exc;
    } id_ex_t;

    // execute result on its way to write-back.
    typedef struct packed {
        logic [cpu_isa_pkg::RA_W-1:0]       wd;
        logic                               wreg;
        logic [cpu_isa_pkg::REG_W-1:0]      wdata;
        logic [cpu_isa_pkg::REG_W-1:0]      pc;
        logic                               in_delayslot;
        cpu_isa_pkg::exc_e                  exc;
    } ex_wb_t;

    localparam id_ex_t ID_EX_NOP = '{
        alu_op: cpu_isa_pkg::ALU_NOP, alu_sel: cpu_isa_pkg::SEL_NOP,
        op_a: '0, op_b: '0, wd: '0, wreg: 1'b0, pc: '0, link_addr: '0,
        in_delayslot: 1'b0, exc: cpu_isa_pkg::EXC_NONE
    };

    localparam ex_wb_t EX_WB_NOP = '{
        wd: '0, wreg: 1'b0, wdata: '0, pc: '0,
        in_delayslot: 1'b0, exc: cpu_isa_pkg::EXC_NONE
    };

endpackage

//--- hw/reg_file.sv
module reg_file (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic [cpu_isa_pkg::RA_W-1:0]       ra1_i,
    input  logic [cpu_isa_pkg::RA_W-1:0]       ra2_i,
    input  logic [cpu_isa_pkg::RA_W-1:0]       wa_i,
    input  logic                               we_i,
    input  logic [cpu_isa_pkg::REG_W-1:0]      wdata_i,
    output logic [cpu_isa_pkg::REG_W-1:0]      rd1_o,
    output logic [cpu_isa_pkg::REG_W-1:0]      rd2_o
);

    logic [cpu_isa_pkg::REG_W-1:0] regs [1:31];
    logic                          wr_ok;

    // register 0 is hardwired, so a write to it is dropped.
    assign wr_ok = we_i && (wa_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wa_i] <= wdata_i;
        end
    end

    // a read of the address being written sees the new data.
    assign rd1_o = (ra1_i == '0) ? '0 :
                   (wr_ok && wa_i == ra1_i) ? wdata_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 :
                   (wr_ok && wa_i == ra2_i) ? wdata_i : regs[ra2_i];

endmodule

//--- hw/inst_decoder.sv
module inst_decoder (
    input  logic [cpu_isa_pkg::REG_W-1:0]      inst_i,
    input  logic [cpu_isa_pkg::REG_W-1:0]      pc_i,
    input  logic                               inst_valid_i,
    input  logic [cpu_isa_pkg::REG_W-1:0]      rd1_i,
    input  logic [cpu_isa_pkg::REG_W-1:0]      rd2_i,
    input  cpu_pipe_pkg::ex_wb_t               ex_fwd_i,
    input  cpu_pipe_pkg::ex_wb_t               wb_fwd_i,
    input  logic                               in_delayslot_i,
    output logic [cpu_isa_pkg::RA_W-1:0]       ra1_o,
    output logic [cpu_isa_pkg::RA_W-1:0]       ra2_o,
    output cpu_pipe_pkg::id_ex_t               bundle_o,
    output logic                               next_in_delayslot_o
);

    logic [5:0]                    opcode;
    logic [5:0]                    funct;
    logic [4:0]                    rs;
    logic [4:0]                    rt;
    logic [4:0]                    rd;
    logic [4:0]                    shamt;
    logic [15:0]                   imm;
    logic [cpu_isa_pkg::REG_W-1:0] rs_val;
    logic [cpu_isa_pkg::REG_W-1:0] rt_val;
    cpu_pipe_pkg::id_ex_t          dec;
    logic                          branch;

    // the newest producer wins, execute before write-back before the file.
    function automatic logic [cpu_isa_pkg::REG_W-1:0] pick_operand(
        input logic [cpu_isa_pkg::RA_W-1:0]  addr,
        input logic [cpu_isa_pkg::REG_W-1:0] rf_data,
        input cpu_pipe_pkg::ex_wb_t          ex_r,
        input cpu_pipe_pkg::ex_wb_t          wb_r
    );
        if (addr == '0) return '0;
        if (ex_r.wreg && ex_r.wd == addr) return ex_r.wdata;
        if (wb_r.wreg && wb_r.wd == addr) return wb_r.wdata;
        return rf_data;
    endfunction

    function automatic cpu_isa_pkg::alu_sel_e sel_of(input cpu_isa_pkg::alu_op_e op);
        case (op)
            cpu_isa_pkg::ALU_ADD, cpu_isa_pkg::ALU_ADDU,
            cpu_isa_pkg::ALU_SUB, cpu_isa_pkg::ALU_SUBU: return cpu_isa_pkg::SEL_ARITH;
            cpu_isa_pkg::ALU_AND, cpu_isa_pkg::ALU_OR, cpu_isa_pkg::ALU_XOR,
            cpu_isa_pkg::ALU_NOR, cpu_isa_pkg::ALU_LUI: return cpu_isa_pkg::SEL_LOGIC;
            cpu_isa_pkg::ALU_SLL, cpu_isa_pkg::ALU_SRL,
            cpu_isa_pkg::ALU_SRA: return cpu_isa_pkg::SEL_SHIFT;
            cpu_isa_pkg::ALU_SLT, cpu_isa_pkg::ALU_SLTU: return cpu_isa_pkg::SEL_COMPARE;
            cpu_isa_pkg::ALU_LINK: return cpu_isa_pkg::SEL_JUMP;
            default: return cpu_isa_pkg::SEL_NOP;
        endcase
    endfunction

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm    = inst_i[15:0];
    assign ra1_o  = rs;
    assign ra2_o  = rt;

    assign rs_val = pick_operand(rs, rd1_i, ex_fwd_i, wb_fwd_i);
    assign rt_val = pick_operand(rt, rd2_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        dec = cpu_pipe_pkg::ID_EX_NOP;
        branch = 1'b0;
        dec.op_a = rs_val;
        dec.op_b = rt_val;
        dec.pc = pc_i;
        dec.link_addr = pc_i + 32'd8;
        dec.in_delayslot = in_delayslot_i;
        dec.wd = rt;
        dec.wreg = 1'b1;
        case (opcode)
            cpu_isa_pkg::OP_SPECIAL: begin
                dec.wd = rd;
                case (funct)
                    cpu_isa_pkg::FN_ADD:  dec.alu_op = cpu_isa_pkg::ALU_ADD;
                    cpu_isa_pkg::FN_ADDU: dec.alu_op = cpu_isa_pkg::ALU_ADDU;
                    cpu_isa_pkg::FN_SUB:  dec.alu_op = cpu_isa_pkg::ALU_SUB;
                    cpu_isa_pkg::FN_SUBU: dec.alu_op = cpu_isa_pkg::ALU_SUBU;
                    cpu_isa_pkg::FN_AND:  dec.alu_op = cpu_isa_pkg::ALU_AND;
                    cpu_isa_pkg::FN_OR:   dec.alu_op = cpu_isa_pkg::ALU_OR;
                    cpu_isa_pkg::FN_XOR:  dec.alu_op = cpu_isa_pkg::ALU_XOR;
                    cpu_isa_pkg::FN_NOR:  dec.alu_op = cpu_isa_pkg::ALU_NOR;
                    cpu_isa_pkg::FN_SLT:  dec.alu_op = cpu_isa_pkg::ALU_SLT;
                    cpu_isa_pkg::FN_SLTU: dec.alu_op = cpu_isa_pkg::ALU_SLTU;
                    cpu_isa_pkg::FN_SLLV: dec.alu_op = cpu_isa_pkg::ALU_SLL;
                    cpu_isa_pkg::FN_SRLV: dec.alu_op = cpu_isa_pkg::ALU_SRL;
                    cpu_isa_pkg::FN_SRAV: dec.alu_op = cpu_isa_pkg::ALU_SRA;
                    cpu_isa_pkg::FN_SLL:  dec.alu_op = cpu_isa_pkg::ALU_SLL;
                    cpu_isa_pkg::FN_SRL:  dec.alu_op = cpu_isa_pkg::ALU_SRL;
                    cpu_isa_pkg::FN_SRA:  dec.alu_op = cpu_isa_pkg::ALU_SRA;
                    default: begin
                        dec.wreg = 1'b0;
                        dec.exc = cpu_isa_pkg::EXC_RI;
                    end
                endcase
                // constant shifts take the amount from the instruction word.
                if (funct[5:2] == 4'b0000) begin
                    dec.op_a = {27'd0, shamt};
                end
            end
            cpu_isa_pkg::OP_ADDI, cpu_isa_pkg::OP_ADDIU,
            cpu_isa_pkg::OP_SLTI, cpu_isa_pkg::OP_SLTIU: begin
                dec.op_b = {{16{imm[15]}}, imm};
                case (opcode)
                    cpu_isa_pkg::OP_ADDI:  dec.alu_op = cpu_isa_pkg::ALU_ADD;
                    cpu_isa_pkg::OP_ADDIU: dec.alu_op = cpu_isa_pkg::ALU_ADDU;
                    cpu_isa_pkg::OP_SLTI:  dec.alu_op = cpu_isa_pkg::ALU_SLT;
                    default:               dec.alu_op = cpu_isa_pkg::ALU_SLTU;
                endcase
            end
            cpu_isa_pkg::OP_ANDI, cpu_isa_pkg::OP_ORI, cpu_isa_pkg::OP_XORI: begin
                dec.op_b = {16'd0, imm};
                case (opcode)
                    cpu_isa_pkg::OP_ANDI: dec.alu_op = cpu_isa_pkg::ALU_AND;
                    cpu_isa_pkg::OP_ORI:  dec.alu_op = cpu_isa_pkg::ALU_OR;
                    default:              dec.alu_op = cpu_isa_pkg::ALU_XOR;
                endcase
            end
            cpu_isa_pkg::OP_LUI: begin
                dec.op_b = {imm, 16'd0};
                dec.alu_op = cpu_isa_pkg::ALU_LUI;
            end
            cpu_isa_pkg::OP_J, cpu_isa_pkg::OP_BEQ, cpu_isa_pkg::OP_BNE: begin
                dec.wreg = 1'b0;
                branch = 1'b1;
            end
            cpu_isa_pkg::OP_JAL: begin
                dec.wd = cpu_isa_pkg::LINK_REG;
                dec.alu_op = cpu_isa_pkg::ALU_LINK;
                branch = 1'b1;
            end
            cpu_isa_pkg::OP_REGIMM: begin
                if (rt == cpu_isa_pkg::RT_BGEZAL) begin
                    // the link is written whether or not the branch is taken.
                    dec.wd = cpu_isa_pkg::LINK_REG;
                    dec.alu_op = cpu_isa_pkg::ALU_LINK;
                    branch = 1'b1;
                end else begin
                    dec.wreg = 1'b0;
                    dec.exc = cpu_isa_pkg::EXC_RI;
                end
            end
            default: begin
                dec.wreg = 1'b0;
                dec.exc = cpu_isa_pkg::EXC_RI;
            end
        endcase
        dec.alu_sel = sel_of(dec.alu_op);
        if (!inst_valid_i) begin
            dec = cpu_pipe_pkg::ID_EX_NOP;
            branch = 1'b0;
        end
    end

    assign bundle_o = dec;
    assign next_in_delayslot_o = branch;

endmodule

//--- hw/stage_reg.sv
module stage_reg #(
    parameter type      payload_t = logic,
    parameter payload_t CLR       = payload_t'('0)
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     en_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // flush wins over a held stage.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= CLR;
        end else if (flush_i) begin
            q_o <= CLR;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- hw/id_ex_reg.sv
module id_ex_reg (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 en_i,
    input  logic                 flush_i,
    input  logic                 fetch_i,
    input  cpu_pipe_pkg::id_ex_t bundle_i,
    input  logic                 next_in_delayslot_i,
    output cpu_pipe_pkg::id_ex_t bundle_o,
    output logic                 in_delayslot_o
);

    logic [1:0] fetch_hist;
    logic       ds_sticky;
    logic       ds_release;

    stage_reg #(
        .payload_t (cpu_pipe_pkg::id_ex_t),
        .CLR       (cpu_pipe_pkg::ID_EX_NOP)
    ) stage0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .en_i     (en_i),
        .flush_i  (flush_i),
        .d_i      (bundle_i),
        .q_o      (bundle_o)
    );

    // a fetch pulse reaches this boundary two cycles later.
    assign ds_release = fetch_hist[1];

    // a branch seen while the fetch is still busy is kept until the slot arrives.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_hist <= '0;
            ds_sticky <= 1'b0;
            in_delayslot_o <= 1'b0;
        end else if (flush_i) begin
            fetch_hist <= '0;
            ds_sticky <= 1'b0;
            in_delayslot_o <= 1'b0;
        end else begin
            fetch_hist <= {fetch_hist[0], fetch_i};
            if (ds_release) begin
                in_delayslot_o <= ds_sticky | next_in_delayslot_i;
                ds_sticky <= 1'b0;
            end else if (en_i) begin
                ds_sticky <= ds_sticky | next_in_delayslot_i;
            end
        end
    end

endmodule

//--- hw/alu_exec.sv
module alu_exec (
    input  cpu_pipe_pkg::id_ex_t bundle_i,
    output cpu_pipe_pkg::ex_wb_t result_o
);

    logic [cpu_isa_pkg::REG_W-1:0] a;
    logic [cpu_isa_pkg::REG_W-1:0] b;
    logic [cpu_isa_pkg::REG_W-1:0] sum;
    logic [cpu_isa_pkg::REG_W-1:0] diff;
    logic [cpu_isa_pkg::REG_W-1:0] arith_res;
    logic [cpu_isa_pkg::REG_W-1:0] logic_res;
    logic [cpu_isa_pkg::REG_W-1:0] shift_res;
    logic [cpu_isa_pkg::REG_W-1:0] cmp_res;
    logic [cpu_isa_pkg::REG_W-1:0] wdata;
    logic                          ovf;
    cpu_isa_pkg::exc_e             exc;

    assign a = bundle_i.op_a;
    assign b = bundle_i.op_b;
    assign sum = a + b;
    assign diff = a - b;

    always_comb begin
        arith_res = sum;
        ovf = 1'b0;
        case (bundle_i.alu_op)
            cpu_isa_pkg::ALU_ADD: ovf = (a[31] == b[31]) && (sum[31] != a[31]);
            cpu_isa_pkg::ALU_SUB: begin
                arith_res = diff;
                ovf = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            cpu_isa_pkg::ALU_SUBU: arith_res = diff;
            default: arith_res = sum;
        endcase
    end

    always_comb begin
        case (bundle_i.alu_op)
            cpu_isa_pkg::ALU_AND: logic_res = a & b;
            cpu_isa_pkg::ALU_OR:  logic_res = a | b;
            cpu_isa_pkg::ALU_XOR: logic_res = a ^ b;
            cpu_isa_pkg::ALU_NOR: logic_res = ~(a | b);
            default:              logic_res = b;
        endcase
    end

    // the shift amount sits in op_a and the value in op_b.
    always_comb begin
        case (bundle_i.alu_op)
            cpu_isa_pkg::ALU_SRL: shift_res = b >> a[4:0];
            cpu_isa_pkg::ALU_SRA: shift_res = $signed(b) >>> a[4:0];
            default:              shift_res = b << a[4:0];
        endcase
    end

    assign cmp_res = (bundle_i.alu_op == cpu_isa_pkg::ALU_SLTU) ? {31'd0, a < b} :
                     {31'd0, $signed(a) < $signed(b)};

    always_comb begin
        case (bundle_i.alu_sel)
            cpu_isa_pkg::SEL_ARITH:   wdata = arith_res;
            cpu_isa_pkg::SEL_LOGIC:   wdata = logic_res;
            cpu_isa_pkg::SEL_SHIFT:   wdata = shift_res;
            cpu_isa_pkg::SEL_COMPARE: wdata = cmp_res;
            cpu_isa_pkg::SEL_JUMP:    wdata = bundle_i.link_addr;
            default:                  wdata = '0;
        endcase
    end

    // a decode exception takes precedence over overflow.
    assign exc = (bundle_i.exc != cpu_isa_pkg::EXC_NONE) ? bundle_i.exc :
                 ovf ? cpu_isa_pkg::EXC_OV : cpu_isa_pkg::EXC_NONE;

    assign result_o.wd = bundle_i.wd;
    assign result_o.wreg = bundle_i.wreg && (exc == cpu_isa_pkg::EXC_NONE);
    assign result_o.wdata = wdata;
    assign result_o.pc = bundle_i.pc;
    assign result_o.in_delayslot = bundle_i.in_delayslot;
    assign result_o.exc = exc;

endmodule

//--- hw/dx_core.sv
module dx_core (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic [cpu_isa_pkg::REG_W-1:0] inst_i,
    input  logic [cpu_isa_pkg::REG_W-1:0] pc_i,
    input  logic                          inst_valid_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          fetch_i,
    output cpu_pipe_pkg::ex_wb_t          result_o,
    output logic                          delay_flag_o
);

    logic [cpu_isa_pkg::RA_W-1:0]  ra1;
    logic [cpu_isa_pkg::RA_W-1:0]  ra2;
    logic [cpu_isa_pkg::REG_W-1:0] rd1;
    logic [cpu_isa_pkg::REG_W-1:0] rd2;
    cpu_pipe_pkg::id_ex_t          id_bundle;
    cpu_pipe_pkg::id_ex_t          ex_bundle;
    cpu_pipe_pkg::ex_wb_t          ex_result;
    logic                          next_ds;

    inst_decoder dec0 (
        .inst_i              (inst_i),
        .pc_i                (pc_i),
        .inst_valid_i        (inst_valid_i),
        .rd1_i               (rd1),
        .rd2_i               (rd2),
        .ex_fwd_i            (ex_result),
        .wb_fwd_i            (result_o),
        .in_delayslot_i      (delay_flag_o),
        .ra1_o               (ra1),
        .ra2_o               (ra2),
        .bundle_o            (id_bundle),
        .next_in_delayslot_o (next_ds)
    );

    reg_file rf0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .ra1_i    (ra1),
        .ra2_i    (ra2),
        .wa_i     (result_o.wd),
        .we_i     (result_o.wreg),
        .wdata_i  (result_o.wdata),
        .rd1_o    (rd1),
        .rd2_o    (rd2)
    );

    id_ex_reg idex0 (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .en_i                (~stall_i),
        .flush_i             (flush_i),
        .fetch_i             (fetch_i),
        .bundle_i            (id_bundle),
        .next_in_delayslot_i (next_ds),
        .bundle_o            (ex_bundle),
        .in_delayslot_o      (delay_flag_o)
    );

    alu_exec alu0 (
        .bundle_i (ex_bundle),
        .result_o (ex_result)
    );

    stage_reg #(
        .payload_t (cpu_pipe_pkg::ex_wb_t),
        .CLR       (cpu_pipe_pkg::EX_WB_NOP)
    ) exwb0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .en_i     (~stall_i),
        .flush_i  (1'b0),
        .d_i      (ex_result),
        .q_o      (result_o)
    );

endmodule

//--- bench/dx_core_checker.sv
module dx_core_checker (
    input logic                 clk,
    input logic                 arst_n_i,
    input logic                 stall_i,
    input logic                 flush_i,
    input cpu_pipe_pkg::ex_wb_t result_i
);

    // an excepting instruction must never write.
    assert property (@(posedge clk) disable iff (!arst_n_i)
        result_i.wreg |-> result_i.exc == cpu_isa_pkg::EXC_NONE)
        else $error("write-back requested together with an exception");

    // a flush empties id/ex, so the result that follows it writes nothing.
    assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i ##1 !stall_i |=> !result_i.wreg)
        else $error("a flushed instruction reached write-back");

    assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(stall_i) |-> $stable(result_i))
        else $error("result changed across a stalled edge");

endmodule

bind dx_core dx_core_checker chk0 (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stall_i  (stall_i),
    .flush_i  (flush_i),
    .result_i (result_o)
);

//--- bench/dx_core_tb.sv
module dx_core_tb;

    logic                          clk;
    logic                          arst_n_i;
    logic [cpu_isa_pkg::REG_W-1:0] inst_i;
    logic [cpu_isa_pkg::REG_W-1:0] pc_i;
    logic                          inst_valid_i;
    logic                          stall_i;
    logic                          flush_i;
    logic                          fetch_i;
    cpu_pipe_pkg::ex_wb_t          result_o;
    logic                          delay_flag_o;

    int          tr_id[$];
    logic [31:0] tr_inst[$];
    logic [31:0] tr_pc[$];
    logic [31:0] tr_wdata[$];
    int          tr_fetch[$];
    int          tr_flush[$];
    int          tr_wreg[$];
    int          tr_wd[$];
    int          tr_exc[$];
    int          tr_ds[$];

    // per-cycle schedule: presented line (-1 for a bubble), stall and fetch strobe.
    int          line_q[$];
    bit          stall_q[$];
    bit          fetch_q[$];
    int          pipe_q[$];

    int          n_lines = 0;
    int          err_count = 0;
    int          test_errs = 0;
    int          cur_test = -1;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_state = 32'h9e03_78a2;

    dx_core dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .inst_valid_i (inst_valid_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .fetch_i      (fetch_i),
        .result_o     (result_o),
        .delay_flag_o (delay_flag_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bit(output bit b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic report_mismatch(input string field, input int line,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0t: line %0d field %s got %h expected %h",
                 $time, line, field, got, exp);
        err_count++;
        test_errs++;
    endtask

    task automatic check_result(input cpu_pipe_pkg::ex_wb_t got,
                                input cpu_pipe_pkg::ex_wb_t exp,
                                input bit cmp_dest, input int line);
        if (got.wreg !== exp.wreg) report_mismatch("wreg", line, 32'(got.wreg), 32'(exp.wreg));
        if (got.exc !== exp.exc) report_mismatch("exc", line, 32'(got.exc), 32'(exp.exc));
        if (got.pc !== exp.pc) report_mismatch("pc", line, got.pc, exp.pc);
        if (got.in_delayslot !== exp.in_delayslot) begin
            report_mismatch("in_delayslot", line, 32'(got.in_delayslot),
                            32'(exp.in_delayslot));
        end
        // a result that writes nothing has no meaningful destination or data.
        if (cmp_dest) begin
            if (got.wd !== exp.wd) report_mismatch("wd", line, 32'(got.wd), 32'(exp.wd));
            if (got.wdata !== exp.wdata) report_mismatch("wdata", line, got.wdata, exp.wdata);
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %0b expected %0b", $time, what, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("test %0d: ok", cur_test);
            tests_passed++;
        end else begin
            $display("test %0d: %0d mismatches", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    task automatic check_line(input int k);
        cpu_pipe_pkg::ex_wb_t exp;
        if (tr_id[k] != cur_test) begin
            if (cur_test >= 0) finish_test();
            cur_test = tr_id[k];
            test_errs = 0;
        end
        exp.wd = tr_wd[k][4:0];
        exp.wreg = tr_wreg[k][0];
        exp.wdata = tr_wdata[k];
        // a flushed instruction leaves an all-zero no-operation behind.
        exp.pc = (tr_flush[k] != 0) ? 32'd0 : tr_pc[k];
        exp.in_delayslot = tr_ds[k][0];
        exp.exc = cpu_isa_pkg::exc_e'(tr_exc[k][1:0]);
        check_result(result_o, exp, tr_wreg[k][0], k);
    endtask

    task automatic load_trace();
        int          fd;
        int          cnt;
        int          id, fe, fl, wr, wd, ex, ds;
        logic [31:0] inst, pc, wdata;
        string       line;
        fd = $fopen("bench/dx_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file bench/dx_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    cnt = $sscanf(line, "%d %h %h %d %d %d %d %h %d %d",
                                  id, inst, pc, fe, fl, wr, wd, wdata, ex, ds);
                    if (cnt == 10) begin
                        tr_id.push_back(id);
                        tr_inst.push_back(inst);
                        tr_pc.push_back(pc);
                        tr_fetch.push_back(fe);
                        tr_flush.push_back(fl);
                        tr_wreg.push_back(wr);
                        tr_wd.push_back(wd);
                        tr_wdata.push_back(wdata);
                        tr_exc.push_back(ex);
                        tr_ds.push_back(ds);
                    end
                end
            end
            $fclose(fd);
            n_lines = tr_id.size();
        end
    endtask

    // the fetch strobe runs two cycles ahead of the edge that takes its instruction.
    task automatic build_schedule();
        int idx;
        bit b1;
        bit b2;
        bit st;
        idx = 0;
        while (idx < n_lines + 2) begin
            take_bit(b1);
            take_bit(b2);
            st = 1'b0;
            if (idx < n_lines && tr_flush[idx] == 0) st = b1 & b2;
            line_q.push_back((idx < n_lines) ? idx : -1);
            stall_q.push_back(st);
            if (!st) idx++;
        end
        for (int c = 0; c < line_q.size(); c++) begin
            if (c + 2 < line_q.size() && !stall_q[c + 2] && line_q[c + 2] >= 0) begin
                fetch_q.push_back(tr_fetch[line_q[c + 2]] != 0);
            end else begin
                fetch_q.push_back(1'b0);
            end
        end
    endtask

    task automatic drive_cycle(input int c);
        int k;
        k = line_q[c];
        stall_i = stall_q[c];
        fetch_i = fetch_q[c];
        inst_valid_i = (k >= 0);
        inst_i = (k >= 0) ? tr_inst[k] : 32'd0;
        pc_i = (k >= 0) ? tr_pc[k] : 32'd0;
        flush_i = (k >= 0) && !stall_q[c] && (tr_flush[k] != 0);
    endtask

    initial begin
        int k;
        arst_n_i = 1'b0;
        inst_i = '0;
        pc_i = '0;
        inst_valid_i = 1'b0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        fetch_i = 1'b0;
        load_trace();
        if (n_lines == 0) begin
            $display("no usable lines were read from the trace file");
            $display("SIMULATION FAILED");
        end else begin
            build_schedule();
            repeat (4) @(posedge clk);
            @(negedge clk);
            arst_n_i = 1'b1;
            check_flag(delay_flag_o, 1'b0, "delay_flag_o after reset");
            for (int c = 0; c < line_q.size(); c++) begin
                drive_cycle(c);
                @(negedge clk);
                if (!stall_q[c]) begin
                    if (flush_i) check_flag(delay_flag_o, 1'b0, "delay_flag_o after flush");
                    pipe_q.push_back(line_q[c]);
                    if (pipe_q.size() > 1) begin
                        k = pipe_q.pop_front();
                        if (k >= 0) check_line(k);
                    end
                end
            end
            if (cur_test >= 0) finish_test();
            $display("tests passed %0d, tests failed %0d, errors %0d",
                     tests_passed, tests_failed, err_count);
            if (err_count == 0 && tests_failed == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
        end
        $finish;
    end

    initial begin
        wait (n_lines > 0);
        #((n_lines * 40 + 4) * 10);
        $display("timeout: the trace did not finish in the expected time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- bench/dx_trace.txt
# test inst pc fetch flush | expected: wreg wd(dec) wdata(hex) exc ds
# exc 0 none, 1 overflow, 2 reserved; wd and wdata only count when wreg is 1
1 24011234 00000100 1 0 1 1 00001234 0 0
1 3c028000 00000104 1 0 1 2 80000000 0 0
1 3423f0f0 00000108 1 0 1 3 0000f2f4 0 0
1 00422020 0000010c 1 0 0 4 00000000 1 0
1 00022903 00000110 1 0 1 5 f8000000 0 0
1 00603027 00000114 1 0 1 6 ffff0d0b 0 0
1 00a1382a 00000118 1 0 1 7 00000001 0 0
1 00a1402b 0000011c 1 0 1 8 00000000 0 0
2 24090005 00000120 1 0 1 9 00000005 0 0
2 01295021 00000124 1 0 1 10 0000000a 0 0
2 01495823 00000128 1 0 1 11 00000005 0 0
2 25600007 0000012c 1 0 1 0 0000000c 0 0
2 000b6025 00000130 1 0 1 12 00000005 0 0
3 0c000040 00000134 1 0 1 31 0000013c 0 0
3 240d0001 00000138 1 0 1 13 00000001 0 1
3 25ae0001 0000013c 1 0 1 14 00000002 0 0
3 05d10010 00000140 1 0 1 31 00000148 0 0
3 03e07821 00000144 1 0 1 15 00000148 0 1
3 39f000ff 00000148 1 0 1 16 000001b7 0 0
3 08000050 0000014c 0 0 0 0 00000000 0 0
3 000e88c0 00000150 1 0 1 17 00000010 0 0
3 2632ffff 00000154 1 0 1 18 0000000f 0 1
3 32530005 00000158 1 0 1 19 00000005 0 0
4 fc000000 0000015c 1 0 0 0 00000000 2 0
4 0021a03f 00000160 1 0 0 20 00000000 2 0
4 04200000 00000164 1 0 0 0 00000000 2 0
5 14220004 00000168 1 0 0 2 00000000 0 0
5 24150077 0000016c 1 1 0 0 00000000 0 0
5 26b60001 00000170 1 0 1 22 00000001 0 0
5 02d3b822 00000174 1 0 1 23 fffffffc 0 0

//--- dx_core.f
hw/cpu_isa_pkg.sv
hw/cpu_pipe_pkg.sv
hw/reg_file.sv
hw/inst_decoder.sv
hw/stage_reg.sv
hw/id_ex_reg.sv
hw/alu_exec.sv
hw/dx_core.sv
bench/dx_core_checker.sv
bench/dx_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dx_core_tb
FILELIST  ?= dx_core.f
BUILD_DIR ?= obj_dir
BIN       ?= dx_core_sim
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(BIN)
	./$(BUILD_DIR)/$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
